//--- logic/pifo_cfg.svh
`ifndef PIFO_CFG_SVH
`define PIFO_CFG_SVH

// --------------------
// Tree shape
// --------------------

// Levels in the tree, root is level 0
`define PIFO_LEVELS 3

// --------------------
// Entry widths
// --------------------

`define PIFO_VAL_W 16   // Stored value, all ones is empty
`define PIFO_CNT_W 4    // Subtree entry counter

// Word address into one level SRAM
// Two bits cover the four leaf words
`define PIFO_ADDR_W 2

`endif

//--- logic/pifo_entry_pkg.sv
`default_nettype none

`include "pifo_cfg.svh"

package pifo_entry_pkg;

    // --------------------
    // Values
    // --------------------
    typedef logic [`PIFO_VAL_W-1:0] pifo_val_t;

    // Marks an unused slot
    localparam pifo_val_t PIFO_EMPTY = '1;

    // --------------------
    // Slots and words
    // --------------------

    // Counter holds entries in the subtree rooted at this slot
    typedef struct packed {
        logic [`PIFO_CNT_W-1:0] cnt;
        pifo_val_t              val;
    } pifo_slot_t;

    // One node pair, one SRAM word
    typedef struct packed {
        pifo_slot_t slot1;
        pifo_slot_t slot0;
    } pifo_pair_t;

endpackage

`default_nettype wire

//--- logic/pifo_ctrl_pkg.sv
`default_nettype none

`include "pifo_cfg.svh"

package pifo_ctrl_pkg;

    // --------------------
    // Node FSM
    // --------------------
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_PUSH = 2'b01,
        ST_POP  = 2'b11,
        ST_WB   = 2'b10    // Pop write-back with child value
    } node_state_t;

    // --------------------
    // Parent to child
    // --------------------

    // Push and pop together are ignored by the receiver
    typedef struct packed {
        logic                     push;
        logic                     pop;
        pifo_entry_pkg::pifo_val_t val;   // Only meaningful with push
        logic [`PIFO_ADDR_W-1:0]  addr;  // Word address in child level
    } node_cmd_t;

endpackage

`default_nettype wire

//--- logic/node_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "pifo_cfg.svh"

module node_sram #(
    parameter int DEPTH = 1
) (
    input  wire logic                       i_clk,
    input  wire logic                       i_arst_n,
    input  wire logic                       i_rd,
    input  wire logic [`PIFO_ADDR_W-1:0]    i_rd_addr,
    input  wire logic                       i_wr,
    input  wire logic [`PIFO_ADDR_W-1:0]    i_wr_addr,
    input  wire pifo_entry_pkg::pifo_pair_t i_wr_data,
    output pifo_entry_pkg::pifo_pair_t      o_rd_data
);

    pifo_entry_pkg::pifo_pair_t mem [DEPTH];
    pifo_entry_pkg::pifo_pair_t rd_word;

    // Storage, starts out with every slot empty
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '{slot1: '{cnt: '0, val: pifo_entry_pkg::PIFO_EMPTY},
                            slot0: '{cnt: '0, val: pifo_entry_pkg::PIFO_EMPTY}};
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (i_wr && i_wr_addr == `PIFO_ADDR_W'(i)) begin
                    mem[i] <= i_wr_data;
                end
            end
        end
    end

    always_comb begin
        rd_word = mem[0];
        for (int i = 1; i < DEPTH; i++) begin
            if (i_rd_addr == `PIFO_ADDR_W'(i)) rd_word = mem[i];
        end
    end

    // Output holds until the next read
    always_ff @(posedge i_clk) begin
        if (i_rd) o_rd_data <= rd_word;
    end

    // Command spacing keeps reads away from words still being written
    a_no_rw_same_addr : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_rd && i_wr && i_rd_addr == i_wr_addr));

endmodule

`default_nettype wire

//--- logic/pifo_pair_update.sv
`timescale 1ns/1ps
`default_nettype none

`include "pifo_cfg.svh"

module pifo_pair_update (
    input  wire pifo_ctrl_pkg::node_state_t i_state,
    input  wire pifo_entry_pkg::pifo_pair_t i_word,          // Word read from SRAM
    input  wire pifo_entry_pkg::pifo_val_t  i_push_val,      // Latched push value
    input  wire pifo_entry_pkg::pifo_val_t  i_child_pop_val,
    output pifo_entry_pkg::pifo_pair_t      o_word,
    output pifo_entry_pkg::pifo_val_t       o_pop_val,
    output logic                            o_child_push,
    output pifo_entry_pkg::pifo_val_t       o_child_push_val,
    output logic                            o_port           // Slot that was touched
);

    localparam logic [`PIFO_CNT_W-1:0] CNT_ONE = `PIFO_CNT_W'(1);

    logic                       cnt_port;
    logic                       val_port;
    pifo_entry_pkg::pifo_slot_t sel_slot;
    pifo_entry_pkg::pifo_slot_t new_slot;

    // --------------------
    // Slot choice
    // --------------------

    // Lighter subtree takes a push, ties to slot 0
    assign cnt_port = (i_word.slot1.cnt < i_word.slot0.cnt);

    // Smaller value leaves on a pop, ties to slot 0
    assign val_port = (i_word.slot1.val < i_word.slot0.val);

    always_comb begin
        if (i_state == pifo_ctrl_pkg::ST_PUSH) begin
            o_port = cnt_port;
        end else begin
            o_port = val_port;
        end
    end

    assign sel_slot = o_port ? i_word.slot1 : i_word.slot0;

    // --------------------
    // Slot rewrite
    // --------------------
    always_comb begin
        new_slot         = sel_slot;
        o_pop_val        = pifo_entry_pkg::PIFO_EMPTY;
        o_child_push     = 1'b0;
        o_child_push_val = i_push_val;

        case (i_state)
            pifo_ctrl_pkg::ST_PUSH: begin
                new_slot.cnt = sel_slot.cnt + CNT_ONE;
                if (sel_slot.val == pifo_entry_pkg::PIFO_EMPTY) begin
                    new_slot.val = i_push_val;             // Free slot, stop here
                end else if (i_push_val < sel_slot.val) begin
                    new_slot.val     = i_push_val;         // New value is the min
                    o_child_push     = 1'b1;
                    o_child_push_val = sel_slot.val;
                end else begin
                    o_child_push     = 1'b1;               // Keep resident, send new one
                    o_child_push_val = i_push_val;
                end
            end

            pifo_ctrl_pkg::ST_POP,
            pifo_ctrl_pkg::ST_WB: begin
                // Only the first pop cycle reports upward
                if (i_state == pifo_ctrl_pkg::ST_POP) begin
                    o_pop_val = sel_slot.val;
                end
                // Empty subtree keeps the word as it is
                if (sel_slot.cnt != '0) begin
                    new_slot.cnt = sel_slot.cnt - CNT_ONE;
                    new_slot.val = i_child_pop_val;        // Refill from below
                end
            end

            default: begin
                new_slot = sel_slot;
            end
        endcase
    end

    // Put the rewritten slot back next to its untouched partner
    always_comb begin
        o_word = i_word;
        if (o_port) begin
            o_word.slot1 = new_slot;
        end else begin
            o_word.slot0 = new_slot;
        end
    end

endmodule

`default_nettype wire

//--- logic/pifo_node.sv
`timescale 1ns/1ps
`default_nettype none

`include "pifo_cfg.svh"

module pifo_node #(
    parameter int LEVEL_IDX = 0
) (
    input  wire logic                       i_clk,
    input  wire logic                       i_arst_n,

    input  wire pifo_ctrl_pkg::node_cmd_t   i_cmd,           // From parent
    output pifo_entry_pkg::pifo_val_t       o_pop_val,       // To parent

    output pifo_ctrl_pkg::node_cmd_t        o_cmd,           // To child
    input  wire pifo_entry_pkg::pifo_val_t  i_child_pop_val, // From child

    output logic                            o_sram_rd,
    output logic [`PIFO_ADDR_W-1:0]         o_sram_rd_addr,
    input  wire pifo_entry_pkg::pifo_pair_t i_sram_rd_data,
    output logic                            o_sram_wr,
    output logic [`PIFO_ADDR_W-1:0]         o_sram_wr_addr,
    output pifo_entry_pkg::pifo_pair_t      o_sram_wr_data
);

    // Leaf level has nothing below it
    localparam bit HAS_CHILD = (LEVEL_IDX < `PIFO_LEVELS - 1);

    pifo_ctrl_pkg::node_state_t state_q;
    pifo_ctrl_pkg::node_state_t state_d;
    pifo_entry_pkg::pifo_val_t  push_val_q;
    logic [`PIFO_ADDR_W-1:0]    addr_q;

    logic                       take_push;
    logic                       take_pop;
    logic                       accept;
    logic                       child_push;
    pifo_entry_pkg::pifo_val_t  child_push_val;
    logic                       port;

    // --------------------
    // Command intake
    // --------------------
    assign take_push = i_cmd.push & ~i_cmd.pop;
    assign take_pop  = i_cmd.pop & ~i_cmd.push;

    // Deaf while in the first pop cycle
    assign accept = (take_push | take_pop) & (state_q != pifo_ctrl_pkg::ST_POP);

    always_comb begin
        case (state_q)
            pifo_ctrl_pkg::ST_POP: begin
                state_d = pifo_ctrl_pkg::ST_WB;
            end
            default: begin
                if (take_push) begin
                    state_d = pifo_ctrl_pkg::ST_PUSH;
                end else if (take_pop) begin
                    state_d = pifo_ctrl_pkg::ST_POP;
                end else begin
                    state_d = pifo_ctrl_pkg::ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= pifo_ctrl_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            push_val_q <= i_cmd.val;
            addr_q     <= i_cmd.addr;   // Word being worked on
        end
    end

    // --------------------
    // Word update
    // --------------------
    pifo_pair_update u_update (
        .i_state          (state_q),
        .i_word           (i_sram_rd_data),
        .i_push_val       (push_val_q),
        .i_child_pop_val  (i_child_pop_val),
        .o_word           (o_sram_wr_data),
        .o_pop_val        (o_pop_val),
        .o_child_push     (child_push),
        .o_child_push_val (child_push_val),
        .o_port           (port)
    );

    // SRAM side, read on accept and write in every busy cycle
    assign o_sram_rd      = accept;
    assign o_sram_rd_addr = i_cmd.addr;
    assign o_sram_wr      = (state_q != pifo_ctrl_pkg::ST_IDLE);
    assign o_sram_wr_addr = addr_q;

    // --------------------
    // Child command
    // --------------------
    always_comb begin
        o_cmd.push = HAS_CHILD & child_push;
        o_cmd.pop  = HAS_CHILD & (state_q == pifo_ctrl_pkg::ST_POP);
        o_cmd.val  = child_push_val;
        o_cmd.addr = {addr_q[`PIFO_ADDR_W-2:0], port};   // 2*addr + port
    end

    // Parent must hold off until the pop has reached write-back
    a_no_cmd_in_pop : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (state_q == pifo_ctrl_pkg::ST_POP) |-> !(i_cmd.push || i_cmd.pop));

endmodule

`default_nettype wire

//--- logic/pifo_tree.sv
`timescale 1ns/1ps
`default_nettype none

`include "pifo_cfg.svh"

module pifo_tree (
    input  wire logic                      i_clk,
    input  wire logic                      i_arst_n,
    input  wire logic                      i_push,
    input  wire pifo_entry_pkg::pifo_val_t i_push_data,
    input  wire logic                      i_pop,
    output pifo_entry_pkg::pifo_val_t      o_pop_data
);

    // Entry i feeds level i, last entry is what the leaf sends down
    pifo_ctrl_pkg::node_cmd_t  cmd     [`PIFO_LEVELS+1];
    pifo_entry_pkg::pifo_val_t pop_val [`PIFO_LEVELS+1];

    // Root always works on word 0
    assign cmd[0] = '{push: i_push, pop: i_pop, val: i_push_data, addr: '0};

    assign pop_val[`PIFO_LEVELS] = pifo_entry_pkg::PIFO_EMPTY;   // Nothing below leaf
    assign o_pop_data            = pop_val[0];

    // --------------------
    // Levels
    // --------------------
    for (genvar lvl = 0; lvl < `PIFO_LEVELS; lvl++) begin : g_level
        logic                       sram_rd;
        logic                       sram_wr;
        logic [`PIFO_ADDR_W-1:0]    rd_addr;
        logic [`PIFO_ADDR_W-1:0]    wr_addr;
        pifo_entry_pkg::pifo_pair_t rd_data;
        pifo_entry_pkg::pifo_pair_t wr_data;

        pifo_node #(.LEVEL_IDX(lvl)) u_node (
            .i_clk           (i_clk),
            .i_arst_n        (i_arst_n),
            .i_cmd           (cmd[lvl]),
            .o_pop_val       (pop_val[lvl]),
            .o_cmd           (cmd[lvl+1]),
            .i_child_pop_val (pop_val[lvl+1]),
            .o_sram_rd       (sram_rd),
            .o_sram_rd_addr  (rd_addr),
            .i_sram_rd_data  (rd_data),
            .o_sram_wr       (sram_wr),
            .o_sram_wr_addr  (wr_addr),
            .o_sram_wr_data  (wr_data)
        );

        node_sram #(.DEPTH(1 << lvl)) u_sram (   // 1, 2, 4 words
            .i_clk     (i_clk),
            .i_arst_n  (i_arst_n),
            .i_rd      (sram_rd),
            .i_rd_addr (rd_addr),
            .i_wr      (sram_wr),
            .i_wr_addr (wr_addr),
            .i_wr_data (wr_data),
            .o_rd_data (rd_data)
        );
    end

endmodule

`default_nettype wire

//--- sim/pifo_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "pifo_cfg.svh"

module pifo_checker #(
    parameter int NAME_W = 96
) (
    input  wire logic                      i_clk,
    input  wire logic                      i_arst_n,
    input  wire logic                      i_push,
    input  wire pifo_entry_pkg::pifo_val_t i_push_data,
    input  wire logic                      i_pop,
    input  wire pifo_entry_pkg::pifo_val_t i_pop_data,
    input  wire logic [NAME_W-1:0]         i_test_name,
    output int                             o_checks,
    output int                             o_pop_errors,
    output int                             o_idle_errors,
    output int                             o_model_errors
);

    // Two slots per node pair, 2 + 4 + 8 for three levels
    localparam int CAPACITY = (1 << (`PIFO_LEVELS + 1)) - 2;

    pifo_entry_pkg::pifo_val_t model [$];   // Ascending, front is the minimum
    logic                      pop_due;
    pifo_entry_pkg::pifo_val_t pop_expect;
    logic [NAME_W-1:0]         pop_name;

    task automatic insert_sorted(input pifo_entry_pkg::pifo_val_t val);
        int pos;
        pos = 0;
        while (pos < model.size() && model[pos] <= val) pos++;
        model.insert(pos, val);
    endtask

    // --------------------
    // Compare and track
    // --------------------
    always @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            model.delete();
            pop_due        <= 1'b0;
            pop_expect     <= pifo_entry_pkg::PIFO_EMPTY;
            pop_name       <= '0;
            o_checks       <= 0;
            o_pop_errors   <= 0;
            o_idle_errors  <= 0;
            o_model_errors <= 0;
        end else begin
            // Popped value shows up one cycle after the strobe
            if (pop_due) begin
                o_checks <= o_checks + 1;
                if (i_pop_data !== pop_expect) begin
                    $display("error: test %s expected %h actual %h",
                             pop_name, pop_expect, i_pop_data);
                    o_pop_errors <= o_pop_errors + 1;
                end
            end else if (i_pop_data !== pifo_entry_pkg::PIFO_EMPTY) begin
                $display("error: test %s expected %h actual %h outside a pop cycle",
                         i_test_name, pifo_entry_pkg::PIFO_EMPTY, i_pop_data);
                o_idle_errors <= o_idle_errors + 1;
            end

            pop_due <= 1'b0;
            if (i_push && !i_pop) begin
                if (model.size() < CAPACITY) begin
                    insert_sorted(i_push_data);
                end else begin
                    $display("queue already full, push of %h in test %s would be lost",
                             i_push_data, i_test_name);
                    o_model_errors <= o_model_errors + 1;
                end
            end else if (i_pop && !i_push) begin
                pop_due  <= 1'b1;
                pop_name <= i_test_name;
                if (model.size() == 0) begin
                    pop_expect <= pifo_entry_pkg::PIFO_EMPTY;   // Empty queue
                end else begin
                    pop_expect <= model.pop_front();
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_pifo_tree.sv
`timescale 1ns/1ps
`default_nettype none

`include "pifo_cfg.svh"

module tb_pifo_tree;

    localparam int          CLK_PERIOD = 20;
    localparam int          DRIVE_DLY  = 2;    // Inputs move after the rising edge
    localparam int          RESET_CYC  = 3;
    localparam int          ROW_CYC    = 4;    // Spacing between commands
    localparam int          NAME_W     = 96;   // Up to twelve characters
    localparam int          CAPACITY   = (1 << (`PIFO_LEVELS + 1)) - 2;
    localparam logic [31:0] SEED       = 32'hec4a9d7c;

    typedef struct packed {
        logic [NAME_W-1:0]         name;
        logic                      push;
        logic                      pop;
        pifo_entry_pkg::pifo_val_t val;
    } stim_row_t;

    logic                      clk;
    logic                      arst_n;
    logic                      push;
    logic                      pop;
    pifo_entry_pkg::pifo_val_t push_data;
    pifo_entry_pkg::pifo_val_t pop_data;
    logic [NAME_W-1:0]         test_name;

    stim_row_t stim [$];
    int        cycle_count;
    int        cycle_limit;
    int        pop_rows;
    int        checks;
    int        pop_errors;
    int        idle_errors;
    int        model_errors;

    pifo_tree dut (
        .i_clk       (clk),
        .i_arst_n    (arst_n),
        .i_push      (push),
        .i_push_data (push_data),
        .i_pop       (pop),
        .o_pop_data  (pop_data)
    );

    pifo_checker #(.NAME_W(NAME_W)) u_checker (
        .i_clk          (clk),
        .i_arst_n       (arst_n),
        .i_push         (push),
        .i_push_data    (push_data),
        .i_pop          (pop),
        .i_pop_data     (pop_data),
        .i_test_name    (test_name),
        .o_checks       (checks),
        .o_pop_errors   (pop_errors),
        .o_idle_errors  (idle_errors),
        .o_model_errors (model_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Anything below all ones is a legal value
    function automatic pifo_entry_pkg::pifo_val_t random_value();
        return pifo_entry_pkg::pifo_val_t'(
            $urandom_range(32'(pifo_entry_pkg::PIFO_EMPTY) - 1, 0));
    endfunction

    task automatic add_row(input logic [NAME_W-1:0] name, input logic do_push,
                           input logic do_pop, input pifo_entry_pkg::pifo_val_t val);
        stim_row_t row;
        row.name = name;
        row.push = do_push;
        row.pop  = do_pop;
        row.val  = val;
        stim.push_back(row);
    endtask

    // --------------------
    // Stimulus table
    // --------------------
    task automatic build_table();
        int   fill;
        logic do_push;
        add_row("single", 1'b1, 1'b0, 16'h1234);
        add_row("single", 1'b0, 1'b1, pifo_entry_pkg::PIFO_EMPTY);
        for (int i = 0; i < 5; i++) add_row("ascending", 1'b1, 1'b0, random_value());
        for (int i = 0; i < 5; i++) add_row("ascending", 1'b0, 1'b1, pifo_entry_pkg::PIFO_EMPTY);
        add_row("empty_pop", 1'b0, 1'b1, pifo_entry_pkg::PIFO_EMPTY);
        add_row("push_pop", 1'b1, 1'b0, 16'h0300);
        add_row("push_pop", 1'b1, 1'b0, 16'h0150);
        add_row("push_pop", 1'b1, 1'b1, 16'h0010);   // Smaller than both, must not land
        add_row("push_pop", 1'b0, 1'b1, pifo_entry_pkg::PIFO_EMPTY);
        add_row("push_pop", 1'b0, 1'b1, pifo_entry_pkg::PIFO_EMPTY);
        for (int i = 0; i < CAPACITY; i++) add_row("fill_drain", 1'b1, 1'b0, random_value());
        for (int i = 0; i < CAPACITY; i++) begin
            add_row("fill_drain", 1'b0, 1'b1, pifo_entry_pkg::PIFO_EMPTY);
        end
        fill = 0;
        for (int i = 0; i < 30; i++) begin
            if (fill == 0) do_push = 1'b1;
            else if (fill == CAPACITY) do_push = 1'b0;
            else do_push = ($urandom_range(2, 0) != 0);   // Leans toward push
            add_row("interleave", do_push, !do_push,
                    do_push ? random_value() : pifo_entry_pkg::PIFO_EMPTY);
            fill = do_push ? fill + 1 : fill - 1;
        end
    endtask

    // One command strobe, then quiet until the next slot
    task automatic apply_row(input stim_row_t row);
        @(posedge clk);
        #DRIVE_DLY;
        test_name = row.name;
        push      = row.push;
        pop       = row.pop;
        push_data = row.val;
        @(posedge clk);
        #DRIVE_DLY;
        push = 1'b0;
        pop  = 1'b0;
        repeat (ROW_CYC - 2) @(posedge clk);
    endtask

    task automatic print_counts();
        $display("checks %0d, pop errors %0d, idle errors %0d, model errors %0d",
                 checks, pop_errors, idle_errors, model_errors);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        void'($urandom(SEED));
        arst_n      = 1'b0;
        push        = 1'b0;
        pop         = 1'b0;
        push_data   = '0;
        test_name   = "reset";
        cycle_count = 0;
        build_table();
        cycle_limit = ROW_CYC * stim.size() + 20;
        pop_rows    = 0;
        foreach (stim[i]) begin
            if (stim[i].pop && !stim[i].push) pop_rows++;   // Each one owes a compare
        end
        repeat (RESET_CYC) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;
        foreach (stim[i]) apply_row(stim[i]);
        repeat (8) @(posedge clk);   // Last pop and refill settle
        print_counts();
        if (checks != pop_rows) begin
            $display("pop compares %0d do not match the %0d pop rows", checks, pop_rows);
        end
        if (pop_errors + idle_errors + model_errors == 0 && checks == pop_rows) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        @(posedge clk);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the stimulus table did not finish", cycle_count);
        print_counts();
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+logic
logic/pifo_entry_pkg.sv
logic/pifo_ctrl_pkg.sv
logic/node_sram.sv
logic/pifo_pair_update.sv
logic/pifo_node.sv
logic/pifo_tree.sv
sim/pifo_checker.sv
sim/tb_pifo_tree.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pifo_tree
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	$(BIN) | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
